// File: Bender.yml
package:
  name: face_window_stats

sources:
  - source/window_stats_pkg.sv
  - source/integral_builder.sv
  - source/integral_ram.sv
  - source/window_scanner.sv
  - source/window_variance.sv
  - source/std_dev_sqrt.sv
  - source/face_window_stats.sv
  - target: simulation
    files:
      - sim/face_window_stats_tb.sv

// File: face_window_stats.f
source/window_stats_pkg.sv
source/integral_builder.sv
source/integral_ram.sv
source/window_scanner.sv
source/window_variance.sv
source/std_dev_sqrt.sv
source/face_window_stats.sv
sim/face_window_stats_tb.sv

// File: sim/face_window_stats_tb.sv
// Directed testbench for the window statistics front end, streams frames and checks every window
`timescale 1ns/100ps

module face_window_stats_tb;
  import window_stats_pkg::*;

  localparam int CLOCK_PERIOD = 100;
  localparam int NUM_PIXELS   = IMG_WIDTH * IMG_HEIGHT;
  localparam int NUM_WINDOWS  = SCAN_ROWS * SCAN_COLS;
  localparam int FRAME_CYCLES = 1500;
  localparam int NUM_FRAMES   = 9;  // Frames sent over all six tests
  localparam int TIMEOUT      = 2 * NUM_FRAMES * FRAME_CYCLES * CLOCK_PERIOD;

  logic                   clock = 1'b0;
  logic                   reset;
  logic                   pixel_valid;
  logic [PIXEL_WIDTH-1:0] pixel;
  logic                   frame_busy, window_valid, frame_done;
  logic [ROW_WIDTH-1:0]   window_row;
  logic [COL_WIDTH-1:0]   window_col;
  logic [STD_WIDTH-1:0]   std_dev;

  logic [PIXEL_WIDTH-1:0] img [NUM_PIXELS];
  logic [ROW_WIDTH-1:0]   got_row [$];
  logic [COL_WIDTH-1:0]   got_col [$];
  logic [STD_WIDTH-1:0]   got_std [$];
  logic                   got_done [$];
  int                     done_count = 0;
  integer                 seed = 32'ha369;

  // ------------------------------------------------------------
  // DUT, clock and output monitor
  // ------------------------------------------------------------
  face_window_stats i_face_window_stats (
    .clock, .reset, .pixel_valid, .pixel,
    .frame_busy, .window_valid, .window_row, .window_col, .std_dev, .frame_done
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  task automatic stop_run();
    $display("Something failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  always @(negedge clock) begin  // Outputs are stable half a cycle after the edge
    if (window_valid) begin
      assert (frame_busy) else begin
        $display("FAIL frame_busy with a window out: expected 0x1, got 0x%h", frame_busy);
        stop_run();
      end
      got_row.push_back(window_row);
      got_col.push_back(window_col);
      got_std.push_back(std_dev);
      got_done.push_back(frame_done);
    end
    if (frame_done) begin
      assert (window_valid) else begin
        $display("frame_done was raised without a window alongside it");
        stop_run();
      end
      done_count++;
    end
  end

  initial begin
    #(TIMEOUT);
    $display("Watchdog expired before the tests finished");
    stop_run();
  end

  // ------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------
  function automatic logic [STD_WIDTH-1:0] model_std_dev(input int r, input int c);
    longint s1, s2, v, p, candidate;
    logic [STD_WIDTH-1:0] root;
    s1 = 0;
    s2 = 0;
    for (int i = 0; i < WINDOW_SIZE; i++) begin
      for (int j = 0; j < WINDOW_SIZE; j++) begin
        p  = img[(r + i) * IMG_WIDTH + c + j];
        s1 += p;
        s2 += p * p;
      end
    end
    v    = WINDOW_AREA * s2 - s1 * s1;
    root = '0;
    for (int b = STD_WIDTH - 1; b >= 0; b--) begin
      candidate = longint'(root) | (longint'(1) << b);
      if (candidate * candidate <= v) root = STD_WIDTH'(candidate);  // Largest root with square <= v
    end
    return root;
  endfunction

  task automatic fill_flat(input logic [PIXEL_WIDTH-1:0] value);
    foreach (img[i]) img[i] = value;
  endtask

  task automatic fill_random();
    foreach (img[i]) img[i] = PIXEL_WIDTH'($random(seed));
  endtask

  task automatic fill_columns();
    foreach (img[i]) img[i] = ((i % IMG_WIDTH) % 2 == 1) ? 8'hff : 8'h00;
  endtask

  task automatic clear_results();
    got_row.delete();
    got_col.delete();
    got_std.delete();
    got_done.delete();
  endtask

  // ------------------------------------------------------------
  // Stimulus and checks
  // ------------------------------------------------------------
  task automatic stream_frame();
    for (int i = 0; i < NUM_PIXELS; i++) begin
      @(posedge clock);
      pixel_valid <= 1'b1;
      pixel       <= img[i];
    end
    @(posedge clock);
    pixel_valid <= 1'b0;
    assert (frame_busy) else begin
      $display("FAIL frame_busy while loading: expected 0x1, got 0x%h", frame_busy);
      stop_run();
    end
  endtask

  task automatic wait_frame_done(input int start_count);
    int cycles;
    cycles = 0;
    while (done_count == start_count) begin
      @(posedge clock);
      cycles++;
      assert (cycles < FRAME_CYCLES) else begin
        $display("frame_done did not arrive within %0d cycles", FRAME_CYCLES);
        stop_run();
      end
    end
  endtask

  task automatic check_frame();
    int r, c;
    logic [STD_WIDTH-1:0] expected;
    assert (got_std.size() == NUM_WINDOWS) else begin
      $display("Expected %0d windows in the frame but got %0d", NUM_WINDOWS, got_std.size());
      stop_run();
    end
    for (int k = 0; k < NUM_WINDOWS; k++) begin
      r        = k / SCAN_COLS;  // Raster order, column steps first
      c        = k % SCAN_COLS;
      expected = model_std_dev(r, c);
      assert (got_row[k] == ROW_WIDTH'(r)) else begin
        $display("FAIL window_row at window %0d: expected 0x%h, got 0x%h", k, r, got_row[k]);
        stop_run();
      end
      assert (got_col[k] == COL_WIDTH'(c)) else begin
        $display("FAIL window_col at window %0d: expected 0x%h, got 0x%h", k, c, got_col[k]);
        stop_run();
      end
      assert (got_std[k] == expected) else begin
        $display("FAIL std_dev at window %0d: expected 0x%h, got 0x%h", k, expected, got_std[k]);
        stop_run();
      end
      assert (got_done[k] == (k == NUM_WINDOWS - 1)) else begin
        $display("FAIL frame_done at window %0d: expected 0x%h, got 0x%h",
                 k, (k == NUM_WINDOWS - 1), got_done[k]);
        stop_run();
      end
    end
  endtask

  task automatic run_frame();
    int start;
    clear_results();
    start = done_count;
    stream_frame();
    wait_frame_done(start);
    @(negedge clock);
    assert (frame_busy == 1'b0) else begin
      $display("FAIL frame_busy after frame_done: expected 0x0, got 0x%h", frame_busy);
      stop_run();
    end
    check_frame();
  endtask

  task automatic check_quiet();
    assert (frame_busy == 1'b0 && window_valid == 1'b0 && frame_done == 1'b0) else begin
      $display("FAIL frame_busy/window_valid/frame_done: expected 0x0/0x0/0x0, got 0x%h/0x%h/0x%h",
               frame_busy, window_valid, frame_done);
      stop_run();
    end
  endtask

  // ------------------------------------------------------------
  // Tests
  // ------------------------------------------------------------
  task automatic flat_image();
    fill_flat(8'h5a);
    run_frame();
  endtask

  task automatic random_image();
    fill_random();
    run_frame();
  endtask

  task automatic extreme_values();
    fill_columns();  // Half the window at 255 gives the widest sums
    run_frame();
  endtask

  task automatic back_to_back_frames();
    fill_random();
    run_frame();
    fill_random();
    run_frame();
  endtask

  task automatic pixels_while_busy();
    int start, cycles;
    fill_random();
    clear_results();
    start  = done_count;
    cycles = 0;
    stream_frame();
    while (done_count == start) begin
      @(posedge clock);
      cycles++;
      assert (cycles < FRAME_CYCLES) else begin
        $display("frame_done did not arrive while junk pixels were driven");
        stop_run();
      end
      pixel_valid <= (got_std.size() > 0);  // Junk only once the scan is well under way
      pixel       <= PIXEL_WIDTH'($random(seed));
    end
    pixel_valid <= 1'b0;
    check_frame();
    fill_random();
    run_frame();
  endtask

  task automatic reset_mid_scan();
    int cycles;
    fill_random();
    clear_results();
    cycles = 0;
    stream_frame();
    while (got_std.size() < 10) begin
      @(posedge clock);
      cycles++;
      assert (cycles < FRAME_CYCLES) else begin
        $display("No windows came out before the reset point");
        stop_run();
      end
    end
    reset <= 1'b1;
    repeat (3) begin
      @(negedge clock);
      check_quiet();
    end
    @(posedge clock);
    reset <= 1'b0;
    repeat (2 * PIPE_LATENCY) begin
      @(negedge clock);
      check_quiet();
    end
    fill_random();
    run_frame();
  endtask

  initial begin
    reset       = 1'b1;
    pixel_valid = 1'b0;
    pixel       = '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    flat_image();
    random_image();
    extreme_values();
    back_to_back_frames();
    pixels_while_busy();
    reset_mid_scan();
    $display("Everything OK");
    $finish;
  end

endmodule

// File: source/face_window_stats.sv
// Top level of the window statistics front end, streams a frame in and reports per-window std dev
`timescale 1ns/100ps

module face_window_stats (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    pixel_valid,
  input  logic [window_stats_pkg::PIXEL_WIDTH-1:0] pixel,
  output logic                                    frame_busy,
  output logic                                    window_valid,
  output logic [window_stats_pkg::ROW_WIDTH-1:0]   window_row,
  output logic [window_stats_pkg::COL_WIDTH-1:0]   window_col,
  output logic [window_stats_pkg::STD_WIDTH-1:0]   std_dev,
  output logic                                    frame_done
);
  import window_stats_pkg::*;

  logic                  write_enable, frame_loaded, loading, scan_active;
  logic [ADDR_WIDTH-1:0] write_addr;
  logic [SUM_WIDTH-1:0]  write_sum;
  logic [SQ_WIDTH-1:0]   write_sq;
  logic [ADDR_WIDTH-1:0] read_addr_a, read_addr_b, read_addr_c, read_addr_d;
  logic [SUM_WIDTH-1:0]  read_sum_a, read_sum_b, read_sum_c, read_sum_d;
  logic [SQ_WIDTH-1:0]   read_sq_a, read_sq_b, read_sq_c, read_sq_d;
  logic                  corner_valid, edge_row, edge_col, scan_last;
  logic [ROW_WIDTH-1:0]  scan_row, var_row;
  logic [COL_WIDTH-1:0]  scan_col, var_col;
  logic                  variance_valid, var_last;
  logic [VAR_WIDTH-1:0]  variance;

  assign frame_busy = loading | scan_active;  // Scan stays active until frame_done

  integral_builder i_integral_builder (
    .clock, .reset, .pixel_valid, .pixel, .scan_active,
    .write_enable, .write_addr, .write_sum, .write_sq, .frame_loaded, .loading
  );

  integral_ram i_integral_ram (
    .clock, .write_enable, .write_addr, .write_sum, .write_sq,
    .read_addr_a, .read_addr_b, .read_addr_c, .read_addr_d,
    .read_sum_a, .read_sum_b, .read_sum_c, .read_sum_d,
    .read_sq_a, .read_sq_b, .read_sq_c, .read_sq_d
  );

  window_scanner i_window_scanner (
    .clock, .reset, .frame_loaded,
    .read_addr_a, .read_addr_b, .read_addr_c, .read_addr_d,
    .corner_valid, .edge_row, .edge_col, .scan_row, .scan_col, .scan_last, .scan_active
  );

  window_variance i_window_variance (
    .clock, .reset, .corner_valid, .edge_row, .edge_col,
    .read_sum_a, .read_sum_b, .read_sum_c, .read_sum_d,
    .read_sq_a, .read_sq_b, .read_sq_c, .read_sq_d,
    .scan_row, .scan_col, .scan_last,
    .variance_valid, .variance, .var_row, .var_col, .var_last
  );

  std_dev_sqrt i_std_dev_sqrt (
    .clock, .reset, .variance_valid, .variance, .var_row, .var_col, .var_last,
    .window_valid, .std_dev, .window_row, .window_col, .frame_done
  );

endmodule

// File: source/integral_builder.sv
// Streams raster pixels into integral and squared-integral words for the integral memory
`timescale 1ns/100ps

module integral_builder (
  input  logic                                    clock,
  input  logic                                    reset,
  input  logic                                    pixel_valid,
  input  logic [window_stats_pkg::PIXEL_WIDTH-1:0] pixel,
  input  logic                                    scan_active,
  output logic                                    write_enable,
  output logic [window_stats_pkg::ADDR_WIDTH-1:0]  write_addr,
  output logic [window_stats_pkg::SUM_WIDTH-1:0]   write_sum,
  output logic [window_stats_pkg::SQ_WIDTH-1:0]    write_sq,
  output logic                                    frame_loaded,
  output logic                                    loading
);
  import window_stats_pkg::*;

  logic [COL_WIDTH-1:0]     col;
  logic [ROW_WIDTH-1:0]     row;
  logic [ADDR_WIDTH-1:0]    addr;
  logic                     filled;
  logic                     accept;
  logic                     last_pixel;
  logic [2*PIXEL_WIDTH-1:0] pixel_sq;
  logic [SUM_WIDTH-1:0]     row_sum, row_sum_next, sum_above;
  logic [SQ_WIDTH-1:0]      row_sq, row_sq_next, sq_above;
  logic [SUM_WIDTH-1:0]     line_sum [IMG_WIDTH];  // Integral words of the row above
  logic [SQ_WIDTH-1:0]      line_sq [IMG_WIDTH];

  assign accept     = pixel_valid && !filled && !scan_active;  // Frame held until the scan ends
  assign last_pixel = (col == COL_WIDTH'(IMG_WIDTH - 1)) && (row == ROW_WIDTH'(IMG_HEIGHT - 1));
  assign pixel_sq   = pixel * pixel;

  assign row_sum_next = ((col == '0) ? '0 : row_sum) + SUM_WIDTH'(pixel);
  assign row_sq_next  = ((col == '0) ? '0 : row_sq) + SQ_WIDTH'(pixel_sq);
  assign sum_above    = (row == '0) ? '0 : line_sum[col];  // Top row has nothing above
  assign sq_above     = (row == '0) ? '0 : line_sq[col];

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      col          <= '0;
      row          <= '0;
      addr         <= '0;
      filled       <= 1'b0;
      loading      <= 1'b0;
      write_enable <= 1'b0;
      frame_loaded <= 1'b0;
    end else begin
      write_enable <= accept;
      frame_loaded <= write_enable && (write_addr == ADDR_WIDTH'(IMG_WIDTH * IMG_HEIGHT - 1));
      if (accept) begin
        loading <= 1'b1;
        addr    <= last_pixel ? '0 : addr + 1'b1;
        filled  <= last_pixel;
        if (col == COL_WIDTH'(IMG_WIDTH - 1)) begin
          col <= '0;
          row <= last_pixel ? '0 : row + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
      end
      if (frame_loaded) begin
        filled  <= 1'b0;
        loading <= 1'b0;  // Scanner takes over busy from the next cycle
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      row_sum       <= row_sum_next;
      row_sq        <= row_sq_next;
      line_sum[col] <= row_sum_next + sum_above;
      line_sq[col]  <= row_sq_next + sq_above;
      write_addr    <= addr;
      write_sum     <= row_sum_next + sum_above;
      write_sq      <= row_sq_next + sq_above;
    end
  end

endmodule

// File: source/integral_ram.sv
// Integral and squared-integral image store with one write port and four registered reads each
`timescale 1ns/100ps

module integral_ram (
  input  logic                                   clock,
  input  logic                                   write_enable,
  input  logic [window_stats_pkg::ADDR_WIDTH-1:0] write_addr,
  input  logic [window_stats_pkg::SUM_WIDTH-1:0]  write_sum,
  input  logic [window_stats_pkg::SQ_WIDTH-1:0]   write_sq,
  input  logic [window_stats_pkg::ADDR_WIDTH-1:0] read_addr_a,
  input  logic [window_stats_pkg::ADDR_WIDTH-1:0] read_addr_b,
  input  logic [window_stats_pkg::ADDR_WIDTH-1:0] read_addr_c,
  input  logic [window_stats_pkg::ADDR_WIDTH-1:0] read_addr_d,
  output logic [window_stats_pkg::SUM_WIDTH-1:0]  read_sum_a,
  output logic [window_stats_pkg::SUM_WIDTH-1:0]  read_sum_b,
  output logic [window_stats_pkg::SUM_WIDTH-1:0]  read_sum_c,
  output logic [window_stats_pkg::SUM_WIDTH-1:0]  read_sum_d,
  output logic [window_stats_pkg::SQ_WIDTH-1:0]   read_sq_a,
  output logic [window_stats_pkg::SQ_WIDTH-1:0]   read_sq_b,
  output logic [window_stats_pkg::SQ_WIDTH-1:0]   read_sq_c,
  output logic [window_stats_pkg::SQ_WIDTH-1:0]   read_sq_d
);
  import window_stats_pkg::*;

  logic [SUM_WIDTH-1:0] sum_mem [IMG_WIDTH * IMG_HEIGHT];
  logic [SQ_WIDTH-1:0]  sq_mem [IMG_WIDTH * IMG_HEIGHT];

  always_ff @(posedge clock) begin
    if (write_enable) begin
      sum_mem[write_addr] <= write_sum;
      sq_mem[write_addr]  <= write_sq;
    end
    read_sum_a <= sum_mem[read_addr_a];  // Corner data returns one cycle after the address
    read_sum_b <= sum_mem[read_addr_b];
    read_sum_c <= sum_mem[read_addr_c];
    read_sum_d <= sum_mem[read_addr_d];
    read_sq_a  <= sq_mem[read_addr_a];
    read_sq_b  <= sq_mem[read_addr_b];
    read_sq_c  <= sq_mem[read_addr_c];
    read_sq_d  <= sq_mem[read_addr_d];
  end

endmodule

// File: source/std_dev_sqrt.sv
// Pipelined restoring square root of the scaled variance, one root bit per stage, tags alongside
`timescale 1ns/100ps

module std_dev_sqrt (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  variance_valid,
  input  logic [window_stats_pkg::VAR_WIDTH-1:0] variance,
  input  logic [window_stats_pkg::ROW_WIDTH-1:0] var_row,
  input  logic [window_stats_pkg::COL_WIDTH-1:0] var_col,
  input  logic                                  var_last,
  output logic                                  window_valid,
  output logic [window_stats_pkg::STD_WIDTH-1:0] std_dev,
  output logic [window_stats_pkg::ROW_WIDTH-1:0] window_row,
  output logic [window_stats_pkg::COL_WIDTH-1:0] window_col,
  output logic                                  frame_done
);
  import window_stats_pkg::*;

  // Index 0 is the stage input, index k the register after stage k
  logic [VAR_WIDTH-1:0] rad [SQRT_STAGES+1];
  logic [REM_WIDTH-1:0] rem [SQRT_STAGES+1];
  logic [STD_WIDTH-1:0] root [SQRT_STAGES+1];
  logic [ROW_WIDTH-1:0] row_q [SQRT_STAGES+1];
  logic [COL_WIDTH-1:0] col_q [SQRT_STAGES+1];
  logic                 valid_q [SQRT_STAGES+1];
  logic                 last_q [SQRT_STAGES+1];

  assign rad[0]     = variance;
  assign rem[0]     = '0;
  assign root[0]    = '0;
  assign row_q[0]   = var_row;
  assign col_q[0]   = var_col;
  assign valid_q[0] = variance_valid;
  assign last_q[0]  = var_last;

  for (genvar k = 0; k < SQRT_STAGES; k++) begin : g_stage
    logic [REM_WIDTH-1:0] shifted;
    logic [REM_WIDTH-1:0] trial;
    logic                 fits;

    assign shifted = {rem[k][REM_WIDTH-3:0], rad[k][VAR_WIDTH-1 -: 2]};  // Bring down two bits
    assign trial   = {root[k], 2'b01};                                   // 4 * root + 1
    assign fits    = (shifted >= trial);

    always_ff @(posedge clock, posedge reset) begin
      if (reset) begin
        valid_q[k+1] <= 1'b0;
        last_q[k+1]  <= 1'b0;
      end else begin
        valid_q[k+1] <= valid_q[k];
        last_q[k+1]  <= last_q[k];
      end
    end

    always_ff @(posedge clock) begin
      rad[k+1]   <= rad[k] << 2;
      rem[k+1]   <= fits ? shifted - trial : shifted;
      root[k+1]  <= {root[k][STD_WIDTH-2:0], fits};
      row_q[k+1] <= row_q[k];
      col_q[k+1] <= col_q[k];
    end
  end

  assign window_valid = valid_q[SQRT_STAGES];
  assign frame_done   = last_q[SQRT_STAGES];  // Last flag only travels with a valid window
  assign std_dev      = root[SQRT_STAGES];
  assign window_row   = row_q[SQRT_STAGES];
  assign window_col   = col_q[SQRT_STAGES];

endmodule

// File: source/window_scanner.sv
// Steps the window over the loaded image and issues four corner addresses per window
`timescale 1ns/100ps

module window_scanner (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic                                   frame_loaded,
  output logic [window_stats_pkg::ADDR_WIDTH-1:0] read_addr_a,
  output logic [window_stats_pkg::ADDR_WIDTH-1:0] read_addr_b,
  output logic [window_stats_pkg::ADDR_WIDTH-1:0] read_addr_c,
  output logic [window_stats_pkg::ADDR_WIDTH-1:0] read_addr_d,
  output logic                                   corner_valid,
  output logic                                   edge_row,
  output logic                                   edge_col,
  output logic [window_stats_pkg::ROW_WIDTH-1:0]  scan_row,
  output logic [window_stats_pkg::COL_WIDTH-1:0]  scan_col,
  output logic                                   scan_last,
  output logic                                   scan_active
);
  import window_stats_pkg::*;

  logic [1:0]             state;
  logic [ROW_WIDTH-1:0]   row, top_row, bottom_row;
  logic [COL_WIDTH-1:0]   col, left_col, right_col;
  logic [DRAIN_WIDTH-1:0] drain_count;
  logic                   issue;
  logic                   last_window;

  function automatic logic [ADDR_WIDTH-1:0] corner_addr(input logic [ROW_WIDTH-1:0] r,
                                                         input logic [COL_WIDTH-1:0] c);
    return ADDR_WIDTH'(r) * ADDR_WIDTH'(IMG_WIDTH) + ADDR_WIDTH'(c);
  endfunction

  assign issue       = (state == ST_SCAN);
  assign scan_active = (state != ST_IDLE);
  assign last_window = (row == ROW_WIDTH'(SCAN_ROWS - 1)) && (col == COL_WIDTH'(SCAN_COLS - 1));

  // Corners at row or column -1 read address 0 and are zeroed downstream
  assign top_row    = (row == '0) ? '0 : row - 1'b1;
  assign left_col   = (col == '0) ? '0 : col - 1'b1;
  assign bottom_row = row + ROW_WIDTH'(WINDOW_SIZE - 1);
  assign right_col  = col + COL_WIDTH'(WINDOW_SIZE - 1);

  assign read_addr_a = corner_addr(bottom_row, right_col);
  assign read_addr_b = corner_addr(top_row, right_col);
  assign read_addr_c = corner_addr(bottom_row, left_col);
  assign read_addr_d = corner_addr(top_row, left_col);

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state        <= ST_IDLE;
      row          <= '0;
      col          <= '0;
      drain_count  <= '0;
      corner_valid <= 1'b0;
      scan_last    <= 1'b0;
    end else begin
      corner_valid <= issue;
      scan_last    <= issue && last_window;
      case (state)
        ST_IDLE: begin
          if (frame_loaded) begin
            state <= ST_SCAN;
            row   <= '0;
            col   <= '0;
          end
        end
        ST_SCAN: begin
          if (last_window) begin
            state       <= ST_DRAIN;
            drain_count <= '0;
          end else if (col == COL_WIDTH'(SCAN_COLS - 1)) begin
            col <= '0;
            row <= row + 1'b1;
          end else begin
            col <= col + 1'b1;
          end
        end
        ST_DRAIN: begin
          if (drain_count == DRAIN_WIDTH'(PIPE_LATENCY - 1)) state <= ST_IDLE;  // frame_done now
          else drain_count <= drain_count + 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    edge_row <= (row == '0);
    edge_col <= (col == '0);
    scan_row <= row;
    scan_col <= col;
  end

endmodule

// File: source/window_stats_pkg.sv
// Image geometry, word widths, scanner states and pipeline latency, imported by every RTL block
package window_stats_pkg;

  // ------------------------------------------------------------
  // Image and window geometry
  // ------------------------------------------------------------
  localparam int IMG_WIDTH   = 40;
  localparam int IMG_HEIGHT  = 30;
  localparam int WINDOW_SIZE = 24;
  localparam int WINDOW_AREA = WINDOW_SIZE * WINDOW_SIZE;
  localparam int SCAN_ROWS   = IMG_HEIGHT - WINDOW_SIZE + 1;
  localparam int SCAN_COLS   = IMG_WIDTH - WINDOW_SIZE + 1;

  // ------------------------------------------------------------
  // Word widths
  // ------------------------------------------------------------
  localparam int PIXEL_WIDTH = 8;
  localparam int SUM_WIDTH   = 20;  // Holds 1200 pixels of 255
  localparam int SQ_WIDTH    = 27;  // Holds 1200 squares of 255
  localparam int VAR_WIDTH   = 48;
  localparam int STD_WIDTH   = 24;
  localparam int ROW_WIDTH   = 5;
  localparam int COL_WIDTH   = 6;
  localparam int ADDR_WIDTH  = 11;

  // ------------------------------------------------------------
  // Pipeline
  // ------------------------------------------------------------
  localparam int SQRT_STAGES  = STD_WIDTH;
  localparam int REM_WIDTH    = STD_WIDTH + 2;     // Square root partial remainder
  localparam int PIPE_LATENCY = 3 + SQRT_STAGES;   // Memory, corner combine, variance, root
  localparam int DRAIN_WIDTH  = $clog2(PIPE_LATENCY);

  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_SCAN  = 2'd1;
  localparam logic [1:0] ST_DRAIN = 2'd2;

endpackage

// File: source/window_variance.sv
// Combines the four corner words into window sums and forms area times square sum minus sum squared
`timescale 1ns/100ps

module window_variance (
  input  logic                                  clock,
  input  logic                                  reset,
  input  logic                                  corner_valid,
  input  logic                                  edge_row,
  input  logic                                  edge_col,
  input  logic [window_stats_pkg::SUM_WIDTH-1:0] read_sum_a,
  input  logic [window_stats_pkg::SUM_WIDTH-1:0] read_sum_b,
  input  logic [window_stats_pkg::SUM_WIDTH-1:0] read_sum_c,
  input  logic [window_stats_pkg::SUM_WIDTH-1:0] read_sum_d,
  input  logic [window_stats_pkg::SQ_WIDTH-1:0]  read_sq_a,
  input  logic [window_stats_pkg::SQ_WIDTH-1:0]  read_sq_b,
  input  logic [window_stats_pkg::SQ_WIDTH-1:0]  read_sq_c,
  input  logic [window_stats_pkg::SQ_WIDTH-1:0]  read_sq_d,
  input  logic [window_stats_pkg::ROW_WIDTH-1:0] scan_row,
  input  logic [window_stats_pkg::COL_WIDTH-1:0] scan_col,
  input  logic                                  scan_last,
  output logic                                  variance_valid,
  output logic [window_stats_pkg::VAR_WIDTH-1:0] variance,
  output logic [window_stats_pkg::ROW_WIDTH-1:0] var_row,
  output logic [window_stats_pkg::COL_WIDTH-1:0] var_col,
  output logic                                  var_last
);
  import window_stats_pkg::*;

  logic [SUM_WIDTH-1:0] sum_b, sum_c, sum_d, win_sum;
  logic [SQ_WIDTH-1:0]  sq_b, sq_c, sq_d, win_sq;
  logic                 sum_valid, sum_last;
  logic [ROW_WIDTH-1:0] sum_row;
  logic [COL_WIDTH-1:0] sum_col;

  assign sum_b = edge_row ? '0 : read_sum_b;
  assign sum_c = edge_col ? '0 : read_sum_c;
  assign sum_d = (edge_row || edge_col) ? '0 : read_sum_d;
  assign sq_b  = edge_row ? '0 : read_sq_b;
  assign sq_c  = edge_col ? '0 : read_sq_c;
  assign sq_d  = (edge_row || edge_col) ? '0 : read_sq_d;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      sum_valid      <= 1'b0;
      sum_last       <= 1'b0;
      variance_valid <= 1'b0;
      var_last       <= 1'b0;
    end else begin
      sum_valid      <= corner_valid;
      sum_last       <= scan_last;
      variance_valid <= sum_valid;
      var_last       <= sum_last;
    end
  end

  always_ff @(posedge clock) begin
    win_sum  <= read_sum_a - sum_b - sum_c + sum_d;  // Wraps back into range, true sum fits
    win_sq   <= read_sq_a - sq_b - sq_c + sq_d;
    sum_row  <= scan_row;
    sum_col  <= scan_col;
    variance <= VAR_WIDTH'(WINDOW_AREA) * VAR_WIDTH'(win_sq)
                - VAR_WIDTH'(win_sum) * VAR_WIDTH'(win_sum);
    var_row  <= sum_row;
    var_col  <= sum_col;
  end

endmodule
